// ==== include/tile_defs.svh ====
`ifndef TILE_DEFS_SVH
`define TILE_DEFS_SVH

// Wishbone bus geometry
`define WB_ADDR_WIDTH 32
`define WB_DATA_WIDTH 32
`define WB_SEL_WIDTH 4

// Memory sizes in words
`define LMEM_WORDS 256
`define BOOTROM_WORDS 16

// Region codes, address bits 31:28
`define REGION_LMEM 4'h0
`define REGION_FIFO 4'hC
`define REGION_ESS 4'hD
`define REGION_BOOT 4'hF

// Base value of every boot ROM word, index is added on top
`define BOOTROM_SIGNATURE 32'hB0070000

// Core interrupt line driven by the Ethernet block
`define ETH_IRQ_BIT 4

`endif

// ==== hdl/wb_pkg.sv ====
`include "tile_defs.svh"

package wb_pkg;

   typedef logic [`WB_ADDR_WIDTH-1:0] wb_addr_t;   // Byte address
   typedef logic [`WB_DATA_WIDTH-1:0] wb_data_t;   // Data word
   typedef logic [`WB_SEL_WIDTH-1:0]  wb_sel_t;    // One bit per byte lane

   // Master owning the shared bus
   typedef enum logic {
      MASTER_IBUS,
      MASTER_DBUS
   } wb_master_e;

endpackage

// ==== hdl/tile_pkg.sv ====
`include "tile_defs.svh"

package tile_pkg;

   typedef logic [3:0]  region_t;    // Address bits 31:28
   typedef logic [31:0] irq_vec_t;   // Core interrupt lines

   typedef enum logic [2:0] {
      SLAVE_LMEM,
      SLAVE_FIFO,
      SLAVE_ESS,
      SLAVE_BOOT,
      SLAVE_NONE
   } slave_e;

   typedef enum logic {
      ARB_IDLE,
      ARB_BUSY
   } arb_state_e;

   // Memory map of the tile, old NA region 0xE falls to SLAVE_NONE
   function automatic slave_e decode_region(region_t region);
      slave_e sel;
      case (region)
         `REGION_LMEM: sel = SLAVE_LMEM;
         `REGION_FIFO: sel = SLAVE_FIFO;
         `REGION_ESS:  sel = SLAVE_ESS;
         `REGION_BOOT: sel = SLAVE_BOOT;
         default:      sel = SLAVE_NONE;
      endcase
      return sel;
   endfunction

endpackage

// ==== hdl/wb_sram_sp.sv ====
`timescale 1ns/1ps
`include "tile_defs.svh"

module wb_sram_sp (
   input  logic             clk,
   input  logic             rst_n_i,
   input  logic             stb_i,
   input  logic             we_i,
   input  wb_pkg::wb_addr_t adr_i,
   input  wb_pkg::wb_sel_t  sel_i,
   input  wb_pkg::wb_data_t dat_i,
   output logic             ack_o,
   output wb_pkg::wb_data_t dat_o
);
   import wb_pkg::*;

   typedef logic [$clog2(`LMEM_WORDS)-1:0] word_idx_t;

   wb_data_t  mem [`LMEM_WORDS];
   wb_data_t  rdat_q;
   word_idx_t idx;
   logic      access;
   logic      ack_q;

   assign idx    = adr_i[$clog2(`LMEM_WORDS)+1:2];   // Word address
   assign access = stb_i & ~ack_q;                    // Edge that issues the ack

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;   // Low for a cycle after each ack
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         if (we_i) begin
            for (int b = 0; b < `WB_SEL_WIDTH; b++) begin
               if (sel_i[b]) begin
                  mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
               end
            end
         end
         rdat_q <= mem[idx];   // Old data on a write
      end
   end

   assign ack_o = ack_q;
   assign dat_o = rdat_q;

endmodule

// ==== hdl/bootrom.sv ====
`timescale 1ns/1ps
`include "tile_defs.svh"

module bootrom (
   input  logic             clk,
   input  logic             rst_n_i,
   input  logic             stb_i,
   input  wb_pkg::wb_addr_t adr_i,
   output logic             ack_o,
   output wb_pkg::wb_data_t dat_o
);
   import wb_pkg::*;

   typedef logic [$clog2(`BOOTROM_WORDS)-1:0] rom_idx_t;

   rom_idx_t idx;
   logic     ack_q;
   wb_data_t rdat_q;

   // Each word is the signature plus its index
   function automatic wb_data_t rom_word(rom_idx_t i);
      return `BOOTROM_SIGNATURE + wb_data_t'(i);
   endfunction

   assign idx = adr_i[$clog2(`BOOTROM_WORDS)+1:2];   // Wraps every 16 words

   // Writes land here too and only get acked
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= stb_i & ~ack_q;
      end
   end

   always_ff @(posedge clk) begin
      if (stb_i) begin
         rdat_q <= rom_word(idx);
      end
   end

   assign ack_o = ack_q;
   assign dat_o = rdat_q;

endmodule

// ==== hdl/wb_bus_arbiter.sv ====
`timescale 1ns/1ps

module wb_bus_arbiter (
   input  logic             clk,
   input  logic             rst_n_i,

   input  logic             ibus_cyc_i,
   input  logic             ibus_stb_i,
   input  logic             ibus_we_i,
   input  wb_pkg::wb_addr_t ibus_adr_i,
   input  wb_pkg::wb_sel_t  ibus_sel_i,
   input  wb_pkg::wb_data_t ibus_dat_i,
   output logic             ibus_ack_o,
   output logic             ibus_err_o,
   output wb_pkg::wb_data_t ibus_dat_o,

   input  logic             dbus_cyc_i,
   input  logic             dbus_stb_i,
   input  logic             dbus_we_i,
   input  wb_pkg::wb_addr_t dbus_adr_i,
   input  wb_pkg::wb_sel_t  dbus_sel_i,
   input  wb_pkg::wb_data_t dbus_dat_i,
   output logic             dbus_ack_o,
   output logic             dbus_err_o,
   output wb_pkg::wb_data_t dbus_dat_o,

   output logic             bus_cyc_o,
   output logic             bus_stb_o,
   output logic             bus_we_o,
   output wb_pkg::wb_addr_t bus_adr_o,
   output wb_pkg::wb_sel_t  bus_sel_o,
   output wb_pkg::wb_data_t bus_dat_o,
   input  logic             bus_ack_i,
   input  logic             bus_err_i,
   input  wb_pkg::wb_data_t bus_dat_i
);
   import wb_pkg::*;
   import tile_pkg::*;

   arb_state_e state_q;
   wb_master_e grant_q;
   logic       busy;
   logic       ibus_own;
   logic       dbus_own;

   assign busy     = (state_q == ARB_BUSY);
   assign ibus_own = busy && (grant_q == MASTER_IBUS);
   assign dbus_own = busy && (grant_q == MASTER_DBUS);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= ARB_IDLE;
         grant_q <= MASTER_IBUS;
      end else begin
         case (state_q)
            ARB_IDLE: begin
               if (dbus_cyc_i) begin        // Data bus has priority
                  grant_q <= MASTER_DBUS;
                  state_q <= ARB_BUSY;
               end else if (ibus_cyc_i) begin
                  grant_q <= MASTER_IBUS;
                  state_q <= ARB_BUSY;
               end
            end
            ARB_BUSY: begin
               // Hold the grant until the owner closes its cycle
               if ((dbus_own && !dbus_cyc_i) || (ibus_own && !ibus_cyc_i)) begin
                  state_q <= ARB_IDLE;
               end
            end
            default: state_q <= ARB_IDLE;
         endcase
      end
   end

   always_comb begin
      if (grant_q == MASTER_DBUS) begin
         bus_cyc_o = dbus_own & dbus_cyc_i;
         bus_stb_o = dbus_own & dbus_stb_i;
         bus_we_o  = dbus_we_i;
         bus_adr_o = dbus_adr_i;
         bus_sel_o = dbus_sel_i;
         bus_dat_o = dbus_dat_i;
      end else begin
         bus_cyc_o = ibus_own & ibus_cyc_i;
         bus_stb_o = ibus_own & ibus_stb_i;
         bus_we_o  = ibus_we_i;
         bus_adr_o = ibus_adr_i;
         bus_sel_o = ibus_sel_i;
         bus_dat_o = ibus_dat_i;
      end
   end

   // Responses go to the owner only
   assign ibus_ack_o = ibus_own & bus_ack_i;
   assign ibus_err_o = ibus_own & bus_err_i;
   assign ibus_dat_o = ibus_own ? bus_dat_i : '0;
   assign dbus_ack_o = dbus_own & bus_ack_i;
   assign dbus_err_o = dbus_own & bus_err_i;
   assign dbus_dat_o = dbus_own ? bus_dat_i : '0;

endmodule

// ==== hdl/wb_bus_decoder.sv ====
`timescale 1ns/1ps

module wb_bus_decoder (
   input  logic             clk,
   input  logic             rst_n_i,

   input  logic             bus_cyc_i,
   input  logic             bus_stb_i,
   input  logic             bus_we_i,
   input  wb_pkg::wb_addr_t bus_adr_i,
   input  wb_pkg::wb_sel_t  bus_sel_i,
   input  wb_pkg::wb_data_t bus_dat_i,
   output logic             bus_ack_o,
   output logic             bus_err_o,
   output wb_pkg::wb_data_t bus_dat_o,

   output logic             lmem_stb_o,
   output logic             lmem_we_o,
   output wb_pkg::wb_addr_t lmem_adr_o,
   output wb_pkg::wb_sel_t  lmem_sel_o,
   output wb_pkg::wb_data_t lmem_dat_o,
   input  logic             lmem_ack_i,
   input  wb_pkg::wb_data_t lmem_dat_i,

   output logic             boot_stb_o,
   output wb_pkg::wb_addr_t boot_adr_o,
   input  logic             boot_ack_i,
   input  wb_pkg::wb_data_t boot_dat_i,

   output logic             fifo_cyc_o,
   output logic             fifo_stb_o,
   output logic             fifo_we_o,
   output wb_pkg::wb_addr_t fifo_adr_o,
   output wb_pkg::wb_sel_t  fifo_sel_o,
   output wb_pkg::wb_data_t fifo_dat_o,
   input  logic             fifo_ack_i,
   input  logic             fifo_err_i,
   input  wb_pkg::wb_data_t fifo_dat_i,

   output logic             ess_cyc_o,
   output logic             ess_stb_o,
   output logic             ess_we_o,
   output wb_pkg::wb_addr_t ess_adr_o,
   output wb_pkg::wb_sel_t  ess_sel_o,
   output wb_pkg::wb_data_t ess_dat_o,
   input  logic             ess_ack_i,
   input  logic             ess_err_i,
   input  wb_pkg::wb_data_t ess_dat_i
);
   import tile_pkg::*;

   region_t region;
   slave_e  slave;
   logic    req;
   logic    err_q;

   assign region = bus_adr_i[31:28];
   assign slave  = decode_region(region);
   assign req    = bus_cyc_i & bus_stb_i;

   assign lmem_stb_o = req & (slave == SLAVE_LMEM);
   assign boot_stb_o = req & (slave == SLAVE_BOOT);
   assign fifo_cyc_o = bus_cyc_i & (slave == SLAVE_FIFO);
   assign fifo_stb_o = req & (slave == SLAVE_FIFO);
   assign ess_cyc_o  = bus_cyc_i & (slave == SLAVE_ESS);
   assign ess_stb_o  = req & (slave == SLAVE_ESS);

   // Request payload fans out to every slave
   assign lmem_we_o  = bus_we_i;
   assign lmem_adr_o = bus_adr_i;
   assign lmem_sel_o = bus_sel_i;
   assign lmem_dat_o = bus_dat_i;
   assign boot_adr_o = bus_adr_i;
   assign fifo_we_o  = bus_we_i;
   assign fifo_adr_o = bus_adr_i;
   assign fifo_sel_o = bus_sel_i;
   assign fifo_dat_o = bus_dat_i;
   assign ess_we_o   = bus_we_i;
   assign ess_adr_o  = bus_adr_i;
   assign ess_sel_o  = bus_sel_i;
   assign ess_dat_o  = bus_dat_i;

   // Error responder for unmapped regions, one pulse per access
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= req & (slave == SLAVE_NONE) & ~err_q;
      end
   end

   always_comb begin
      bus_ack_o = 1'b0;
      bus_err_o = err_q;
      bus_dat_o = '0;
      case (slave)
         SLAVE_LMEM: begin
            bus_ack_o = lmem_ack_i;
            bus_dat_o = lmem_dat_i;
         end
         SLAVE_BOOT: begin
            bus_ack_o = boot_ack_i;
            bus_dat_o = boot_dat_i;
         end
         SLAVE_FIFO: begin
            bus_ack_o = fifo_ack_i;
            bus_err_o = fifo_err_i;
            bus_dat_o = fifo_dat_i;
         end
         SLAVE_ESS: begin
            bus_ack_o = ess_ack_i;
            bus_err_o = ess_err_i;
            bus_dat_o = ess_dat_i;
         end
         default: begin
         end
      endcase
   end

endmodule

// ==== hdl/compute_tile_dm.sv ====
`timescale 1ns/1ps
`include "tile_defs.svh"

module compute_tile_dm (
   input  logic               clk,
   input  logic               rst_n_i,

   input  logic               ibus_cyc_i,
   input  logic               ibus_stb_i,
   input  logic               ibus_we_i,
   input  wb_pkg::wb_addr_t   ibus_adr_i,
   input  wb_pkg::wb_sel_t    ibus_sel_i,
   input  wb_pkg::wb_data_t   ibus_dat_i,
   output logic               ibus_ack_o,
   output logic               ibus_err_o,
   output wb_pkg::wb_data_t   ibus_dat_o,

   input  logic               dbus_cyc_i,
   input  logic               dbus_stb_i,
   input  logic               dbus_we_i,
   input  wb_pkg::wb_addr_t   dbus_adr_i,
   input  wb_pkg::wb_sel_t    dbus_sel_i,
   input  wb_pkg::wb_data_t   dbus_dat_i,
   output logic               dbus_ack_o,
   output logic               dbus_err_o,
   output wb_pkg::wb_data_t   dbus_dat_o,

   output logic               fifo_cyc_o,
   output logic               fifo_stb_o,
   output logic               fifo_we_o,
   output wb_pkg::wb_addr_t   fifo_adr_o,
   output wb_pkg::wb_sel_t    fifo_sel_o,
   output wb_pkg::wb_data_t   fifo_dat_o,
   input  logic               fifo_ack_i,
   input  logic               fifo_err_i,
   input  wb_pkg::wb_data_t   fifo_dat_i,

   output logic               ess_cyc_o,
   output logic               ess_stb_o,
   output logic               ess_we_o,
   output wb_pkg::wb_addr_t   ess_adr_o,
   output wb_pkg::wb_sel_t    ess_sel_o,
   output wb_pkg::wb_data_t   ess_dat_o,
   input  logic               ess_ack_i,
   input  logic               ess_err_i,
   input  wb_pkg::wb_data_t   ess_dat_i,

   input  logic               eth_irq_i,
   output tile_pkg::irq_vec_t pic_ints_o
);
   import wb_pkg::*;

   // Shared bus between arbiter and decoder
   logic     bus_cyc;
   logic     bus_stb;
   logic     bus_we;
   wb_addr_t bus_adr;
   wb_sel_t  bus_sel;
   wb_data_t bus_wdat;
   logic     bus_ack;
   logic     bus_err;
   wb_data_t bus_rdat;

   // Local memory port
   logic     lmem_stb;
   logic     lmem_we;
   wb_addr_t lmem_adr;
   wb_sel_t  lmem_sel;
   wb_data_t lmem_wdat;
   logic     lmem_ack;
   wb_data_t lmem_rdat;

   // Boot ROM port
   logic     boot_stb;
   wb_addr_t boot_adr;
   logic     boot_ack;
   wb_data_t boot_rdat;

   wb_bus_arbiter arbiter_i (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .ibus_cyc_i (ibus_cyc_i),
      .ibus_stb_i (ibus_stb_i),
      .ibus_we_i  (ibus_we_i),
      .ibus_adr_i (ibus_adr_i),
      .ibus_sel_i (ibus_sel_i),
      .ibus_dat_i (ibus_dat_i),
      .ibus_ack_o (ibus_ack_o),
      .ibus_err_o (ibus_err_o),
      .ibus_dat_o (ibus_dat_o),
      .dbus_cyc_i (dbus_cyc_i),
      .dbus_stb_i (dbus_stb_i),
      .dbus_we_i  (dbus_we_i),
      .dbus_adr_i (dbus_adr_i),
      .dbus_sel_i (dbus_sel_i),
      .dbus_dat_i (dbus_dat_i),
      .dbus_ack_o (dbus_ack_o),
      .dbus_err_o (dbus_err_o),
      .dbus_dat_o (dbus_dat_o),
      .bus_cyc_o  (bus_cyc),
      .bus_stb_o  (bus_stb),
      .bus_we_o   (bus_we),
      .bus_adr_o  (bus_adr),
      .bus_sel_o  (bus_sel),
      .bus_dat_o  (bus_wdat),
      .bus_ack_i  (bus_ack),
      .bus_err_i  (bus_err),
      .bus_dat_i  (bus_rdat)
   );

   wb_bus_decoder decoder_i (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .bus_cyc_i  (bus_cyc),
      .bus_stb_i  (bus_stb),
      .bus_we_i   (bus_we),
      .bus_adr_i  (bus_adr),
      .bus_sel_i  (bus_sel),
      .bus_dat_i  (bus_wdat),
      .bus_ack_o  (bus_ack),
      .bus_err_o  (bus_err),
      .bus_dat_o  (bus_rdat),
      .lmem_stb_o (lmem_stb),
      .lmem_we_o  (lmem_we),
      .lmem_adr_o (lmem_adr),
      .lmem_sel_o (lmem_sel),
      .lmem_dat_o (lmem_wdat),
      .lmem_ack_i (lmem_ack),
      .lmem_dat_i (lmem_rdat),
      .boot_stb_o (boot_stb),
      .boot_adr_o (boot_adr),
      .boot_ack_i (boot_ack),
      .boot_dat_i (boot_rdat),
      .fifo_cyc_o (fifo_cyc_o),
      .fifo_stb_o (fifo_stb_o),
      .fifo_we_o  (fifo_we_o),
      .fifo_adr_o (fifo_adr_o),
      .fifo_sel_o (fifo_sel_o),
      .fifo_dat_o (fifo_dat_o),
      .fifo_ack_i (fifo_ack_i),
      .fifo_err_i (fifo_err_i),
      .fifo_dat_i (fifo_dat_i),
      .ess_cyc_o  (ess_cyc_o),
      .ess_stb_o  (ess_stb_o),
      .ess_we_o   (ess_we_o),
      .ess_adr_o  (ess_adr_o),
      .ess_sel_o  (ess_sel_o),
      .ess_dat_o  (ess_dat_o),
      .ess_ack_i  (ess_ack_i),
      .ess_err_i  (ess_err_i),
      .ess_dat_i  (ess_dat_i)
   );

   wb_sram_sp lmem_i (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .stb_i   (lmem_stb),
      .we_i    (lmem_we),
      .adr_i   (lmem_adr),
      .sel_i   (lmem_sel),
      .dat_i   (lmem_wdat),
      .ack_o   (lmem_ack),
      .dat_o   (lmem_rdat)
   );

   bootrom bootrom_i (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .stb_i   (boot_stb),
      .adr_i   (boot_adr),
      .ack_o   (boot_ack),
      .dat_o   (boot_rdat)
   );

   // Only the Ethernet line is wired, the NA lines are gone
   always_comb begin
      pic_ints_o = '0;
      pic_ints_o[`ETH_IRQ_BIT] = eth_irq_i;
   end

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk_o
);
   localparam time HALF_PERIOD = 2ns;   // 4 ns clock

   initial begin
      clk_o = 1'b0;
      forever begin
         #(HALF_PERIOD) clk_o = ~clk_o;
      end
   end

endmodule

// ==== tb/tb_compute_tile.sv ====
`timescale 1ns/1ps
`include "tile_defs.svh"

module tb_compute_tile;
   import wb_pkg::*;
   import tile_pkg::*;

   localparam logic [31:0] SEED     = 32'haba4e35f;
   localparam wb_data_t    FIFO_KEY = 32'h5A5A_0F0F;   // Read data is address XOR key
   localparam wb_data_t    ESS_KEY  = 32'h3C3C_A5A5;
   localparam int          TIMEOUT  = 20;              // Cycles allowed per bus access

   logic clk;
   logic rst_n;

   logic     ibus_cyc, ibus_stb, ibus_we;
   wb_addr_t ibus_adr;
   wb_sel_t  ibus_sel;
   wb_data_t ibus_wdat;
   logic     ibus_ack, ibus_err;
   wb_data_t ibus_rdat;

   logic     dbus_cyc, dbus_stb, dbus_we;
   wb_addr_t dbus_adr;
   wb_sel_t  dbus_sel;
   wb_data_t dbus_wdat;
   logic     dbus_ack, dbus_err;
   wb_data_t dbus_rdat;

   logic     fifo_cyc, fifo_stb, fifo_we;
   wb_addr_t fifo_adr;
   wb_sel_t  fifo_sel;
   wb_data_t fifo_wdat;
   logic     fifo_ack  = 1'b0;
   logic     fifo_err  = 1'b0;
   wb_data_t fifo_rdat = '0;

   logic     ess_cyc, ess_stb, ess_we;
   wb_addr_t ess_adr;
   wb_sel_t  ess_sel;
   wb_data_t ess_wdat;
   logic     ess_ack  = 1'b0;
   logic     ess_err  = 1'b0;
   wb_data_t ess_rdat = '0;

   logic     eth_irq;
   irq_vec_t pic_ints;

   logic [31:0] rng_state = SEED;

   // External slave model state
   logic [31:0] fifo_rng = SEED;
   logic [31:0] ess_rng  = SEED;
   int          fifo_wait = 0;
   int          ess_wait  = 0;
   bit          fifo_busy = 1'b0;
   bit          ess_busy  = 1'b0;
   int          fifo_hits = 0;
   int          ess_hits  = 0;
   int          fifo_cyc_cycles = 0;
   int          ess_cyc_cycles  = 0;
   logic [68:0] fifo_seen = '0;   // {we, sel, adr, dat} as the model saw them
   logic [68:0] ess_seen  = '0;

   tb_clock_gen clock_gen_i (
      .clk_o (clk)
   );

   compute_tile_dm compute_tile_dm_i (
      .clk        (clk),        .rst_n_i    (rst_n),
      .ibus_cyc_i (ibus_cyc),   .ibus_stb_i (ibus_stb),  .ibus_we_i  (ibus_we),
      .ibus_adr_i (ibus_adr),   .ibus_sel_i (ibus_sel),  .ibus_dat_i (ibus_wdat),
      .ibus_ack_o (ibus_ack),   .ibus_err_o (ibus_err),  .ibus_dat_o (ibus_rdat),
      .dbus_cyc_i (dbus_cyc),   .dbus_stb_i (dbus_stb),  .dbus_we_i  (dbus_we),
      .dbus_adr_i (dbus_adr),   .dbus_sel_i (dbus_sel),  .dbus_dat_i (dbus_wdat),
      .dbus_ack_o (dbus_ack),   .dbus_err_o (dbus_err),  .dbus_dat_o (dbus_rdat),
      .fifo_cyc_o (fifo_cyc),   .fifo_stb_o (fifo_stb),  .fifo_we_o  (fifo_we),
      .fifo_adr_o (fifo_adr),   .fifo_sel_o (fifo_sel),  .fifo_dat_o (fifo_wdat),
      .fifo_ack_i (fifo_ack),   .fifo_err_i (fifo_err),  .fifo_dat_i (fifo_rdat),
      .ess_cyc_o  (ess_cyc),    .ess_stb_o  (ess_stb),   .ess_we_o   (ess_we),
      .ess_adr_o  (ess_adr),    .ess_sel_o  (ess_sel),   .ess_dat_o  (ess_wdat),
      .ess_ack_i  (ess_ack),    .ess_err_i  (ess_err),   .ess_dat_i  (ess_rdat),
      .eth_irq_i  (eth_irq),    .pic_ints_o (pic_ints)
   );

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
         else stop_with_error($sformatf("ERROR %s: got 0x%08h, expected 0x%08h",
                                        name, got, exp));
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic string master_name(input bit use_dbus);
      return use_dbus ? "dbus" : "ibus";
   endfunction

   // FIFO model, acks after 0 to 3 cycles and idles a cycle after each response
   always @(negedge clk) begin
      if (fifo_ack || fifo_err) begin
         fifo_ack  = 1'b0;
         fifo_err  = 1'b0;
         fifo_busy = 1'b0;
      end else if (fifo_cyc && fifo_stb) begin
         if (!fifo_busy) begin
            fifo_busy = 1'b1;
            fifo_rng  = xorshift32(fifo_rng);
            fifo_wait = int'(fifo_rng[1:0]);
            fifo_hits++;
            fifo_seen = {fifo_we, fifo_sel, fifo_adr, fifo_wdat};
         end
         if (fifo_wait == 0) begin
            fifo_ack  = 1'b1;
            fifo_rdat = fifo_adr ^ FIFO_KEY;
         end else begin
            fifo_wait--;
         end
      end
   end

   // ESS model, same timing, err when address bit 8 is set
   always @(negedge clk) begin
      if (ess_ack || ess_err) begin
         ess_ack  = 1'b0;
         ess_err  = 1'b0;
         ess_busy = 1'b0;
      end else if (ess_cyc && ess_stb) begin
         if (!ess_busy) begin
            ess_busy = 1'b1;
            ess_rng  = xorshift32(ess_rng);
            ess_wait = int'(ess_rng[1:0]);
            ess_hits++;
            ess_seen = {ess_we, ess_sel, ess_adr, ess_wdat};
         end
         if (ess_wait == 0) begin
            ess_ack  = ~ess_adr[8];
            ess_err  = ess_adr[8];
            ess_rdat = ess_adr ^ ESS_KEY;
         end else begin
            ess_wait--;
         end
      end
   end

   // Bus monitor, sampled just after the rising edge
   always @(posedge clk) begin
      #1;
      if (fifo_cyc) fifo_cyc_cycles++;
      if (ess_cyc) ess_cyc_cycles++;
      assert (!(ibus_ack || ibus_err) || ibus_cyc)
         else stop_with_error("ibus got a response without an open ibus cycle");
      assert (!(dbus_ack || dbus_err) || dbus_cyc)
         else stop_with_error("dbus got a response without an open dbus cycle");
   end

   assert property (@(posedge clk) !(fifo_cyc && ess_cyc))
      else stop_with_error("FIFO and ESS ports were selected in the same cycle");
   assert property (@(posedge clk) !(ibus_ack && ibus_err) && !(dbus_ack && dbus_err))
      else stop_with_error("ack and err were raised together");
   assert property (@(posedge clk) pic_ints == (irq_vec_t'(eth_irq) << `ETH_IRQ_BIT))
      else stop_with_error($sformatf("ERROR pic_ints_o: got 0x%08h, eth_irq_i is 0x%0h",
                                     pic_ints, eth_irq));

   task automatic drive_master(input bit use_dbus, input logic cyc, input wb_addr_t adr,
                               input logic we, input wb_sel_t sel, input wb_data_t dat);
      if (use_dbus) begin
         dbus_cyc  = cyc;
         dbus_stb  = cyc;
         dbus_we   = we;
         dbus_adr  = adr;
         dbus_sel  = sel;
         dbus_wdat = dat;
      end else begin
         ibus_cyc  = cyc;
         ibus_stb  = cyc;
         ibus_we   = we;
         ibus_adr  = adr;
         ibus_sel  = sel;
         ibus_wdat = dat;
      end
   endtask

   // One classic cycle; cycles counts rising edges until ack or err
   task automatic bus_access(input bit use_dbus, input wb_addr_t adr, input logic we,
                             input wb_sel_t sel, input wb_data_t wdat,
                             output wb_data_t rdat, output logic ack, output logic err,
                             output int cycles);
      @(negedge clk);
      drive_master(use_dbus, 1'b1, adr, we, sel, wdat);
      cycles = 0;
      ack    = 1'b0;
      err    = 1'b0;
      rdat   = '0;
      while (!ack && !err) begin
         if (cycles == TIMEOUT) begin
            stop_with_error($sformatf("Timeout: %s got no ack or err within %0d cycles",
                                      master_name(use_dbus), TIMEOUT));
         end
         @(posedge clk);
         #1;
         cycles++;
         ack  = use_dbus ? dbus_ack : ibus_ack;
         err  = use_dbus ? dbus_err : ibus_err;
         rdat = use_dbus ? dbus_rdat : ibus_rdat;
      end
      @(negedge clk);
      drive_master(use_dbus, 1'b0, '0, 1'b0, '0, '0);
   endtask

   task automatic expect_response(input string who, input logic ack, input logic err,
                                  input logic exp_ack, input int cycles, input int exp_cycles);
      check_value({who, "_ack_o"}, 32'(ack), 32'(exp_ack));
      check_value({who, "_err_o"}, 32'(err), 32'(!exp_ack));
      if (exp_cycles > 0) begin
         check_value({who, " latency"}, cycles, exp_cycles);
      end
   endtask

   task automatic idle_outputs_low();
      check_value("ibus_ack_o", 32'(ibus_ack), 32'h0);
      check_value("ibus_err_o", 32'(ibus_err), 32'h0);
      check_value("dbus_ack_o", 32'(dbus_ack), 32'h0);
      check_value("dbus_err_o", 32'(dbus_err), 32'h0);
      check_value("fifo_cyc_o", 32'(fifo_cyc), 32'h0);
      check_value("ess_cyc_o", 32'(ess_cyc), 32'h0);
   endtask

   task automatic lmem_random_access();
      wb_data_t    ref_mem [16];
      wb_data_t    wdat;
      wb_data_t    rdat;
      logic [31:0] r;
      wb_sel_t     sel;
      logic        ack;
      logic        err;
      int          cycles;
      int          idx;
      int          k;
      int          b;
      for (k = 0; k < 16; k++) begin   // Full-word fill first, memory is not reset
         wdat = next_random();
         bus_access(1'b1, wb_addr_t'(4 * k), 1'b1, 4'hF, wdat, rdat, ack, err, cycles);
         expect_response("dbus", ack, err, 1'b1, cycles, 2);
         ref_mem[k] = wdat;
      end
      for (k = 0; k < 48; k++) begin
         r    = next_random();
         idx  = int'(r[3:0]);
         sel  = r[7:4];
         wdat = next_random();
         if (r[8]) begin
            bus_access(1'b1, wb_addr_t'(4 * idx), 1'b1, sel, wdat, rdat, ack, err, cycles);
            expect_response("dbus", ack, err, 1'b1, cycles, 2);
            for (b = 0; b < `WB_SEL_WIDTH; b++) begin
               if (sel[b]) ref_mem[idx][8*b +: 8] = wdat[8*b +: 8];
            end
         end else begin
            bus_access(1'b1, wb_addr_t'(4 * idx), 1'b0, 4'hF, '0, rdat, ack, err, cycles);
            expect_response("dbus", ack, err, 1'b1, cycles, 2);
            check_value("dbus_dat_o", rdat, ref_mem[idx]);
         end
      end
      for (k = 0; k < 16; k++) begin
         bus_access(1'b1, wb_addr_t'(4 * k), 1'b0, 4'hF, '0, rdat, ack, err, cycles);
         expect_response("dbus", ack, err, 1'b1, cycles, 2);
         check_value("dbus_dat_o", rdat, ref_mem[k]);
      end
   endtask

   task automatic boot_rom_reads();
      wb_data_t rdat;
      logic     ack;
      logic     err;
      int       cycles;
      int       i;
      for (i = 0; i < 20; i++) begin   // Past 16 words the index wraps
         bus_access(1'b0, 32'hF000_0000 + wb_addr_t'(4 * i), 1'b0, 4'hF, '0,
                    rdat, ack, err, cycles);
         expect_response("ibus", ack, err, 1'b1, cycles, 2);
         check_value("ibus_dat_o", rdat, `BOOTROM_SIGNATURE + wb_data_t'(i % 16));
      end
      bus_access(1'b0, 32'hF000_0008, 1'b1, 4'hF, 32'h1234_5678, rdat, ack, err, cycles);
      expect_response("ibus", ack, err, 1'b1, cycles, 2);
      bus_access(1'b0, 32'hF000_0008, 1'b0, 4'hF, '0, rdat, ack, err, cycles);
      expect_response("ibus", ack, err, 1'b1, cycles, 2);
      check_value("ibus_dat_o", rdat, `BOOTROM_SIGNATURE + 32'd2);
   endtask

   task automatic unmapped_errors();
      wb_addr_t addrs [2];
      wb_data_t rdat;
      logic     ack;
      logic     err;
      int       cycles;
      int       fifo_before;
      int       ess_before;
      int       k;
      addrs[0] = 32'hE000_0010;   // Former network adapter region
      addrs[1] = 32'h5000_0020;
      for (k = 0; k < 4; k++) begin
         fifo_before = fifo_cyc_cycles;
         ess_before  = ess_cyc_cycles;
         bus_access(k[0], addrs[k / 2], k[0], 4'hF, 32'h0BAD_0000, rdat, ack, err, cycles);
         expect_response(master_name(k[0]), ack, err, 1'b0, cycles, 2);
         check_value("fifo_cyc_o cycles", fifo_cyc_cycles, fifo_before);
         check_value("ess_cyc_o cycles", ess_cyc_cycles, ess_before);
      end
   endtask

   task automatic external_access(input bit use_dbus, input wb_addr_t adr, input logic we,
                                  input wb_sel_t sel, input wb_data_t wdat);
      wb_data_t rdat;
      logic     ack;
      logic     err;
      logic     to_ess;
      logic     exp_ack;
      int       cycles;
      int       fifo_hits_before;
      int       ess_hits_before;
      int       fifo_cyc_before;
      int       ess_cyc_before;
      to_ess           = (adr[31:28] == `REGION_ESS);
      exp_ack          = !(to_ess && adr[8]);
      fifo_hits_before = fifo_hits;
      ess_hits_before  = ess_hits;
      fifo_cyc_before  = fifo_cyc_cycles;
      ess_cyc_before   = ess_cyc_cycles;
      bus_access(use_dbus, adr, we, sel, wdat, rdat, ack, err, cycles);
      expect_response(master_name(use_dbus), ack, err, exp_ack, cycles, 0);
      if (to_ess) begin
         check_value("ess access count", ess_hits, ess_hits_before + 1);
         check_value("fifo_cyc_o cycles", fifo_cyc_cycles, fifo_cyc_before);
         check_value("ess_adr_o", ess_seen[63:32], adr);
         check_value("ess_dat_o", ess_seen[31:0], wdat);
         check_value("ess_we_o/ess_sel_o", 32'(ess_seen[68:64]), 32'({we, sel}));
      end else begin
         check_value("fifo access count", fifo_hits, fifo_hits_before + 1);
         check_value("ess_cyc_o cycles", ess_cyc_cycles, ess_cyc_before);
         check_value("fifo_adr_o", fifo_seen[63:32], adr);
         check_value("fifo_dat_o", fifo_seen[31:0], wdat);
         check_value("fifo_we_o/fifo_sel_o", 32'(fifo_seen[68:64]), 32'({we, sel}));
      end
      if (exp_ack && !we) begin
         check_value({master_name(use_dbus), "_dat_o"}, rdat,
                     adr ^ (to_ess ? ESS_KEY : FIFO_KEY));
      end
   endtask

   task automatic external_ports();
      logic [31:0] r;
      logic [31:0] s;
      wb_addr_t    adr;
      int          k;
      for (k = 0; k < 16; k++) begin
         r   = next_random();
         s   = next_random();
         adr = {r[0] ? `REGION_ESS : `REGION_FIFO, r[27:2], 2'b00};
         external_access(k[0], adr, r[1], s[3:0], next_random());
      end
      external_access(1'b1, 32'hD000_0104, 1'b0, 4'hF, '0);   // ESS error path
      external_access(1'b0, 32'hD000_0204, 1'b0, 4'hF, '0);
      external_access(1'b1, 32'hC000_0100, 1'b1, 4'h3, 32'h7654_3210);
   endtask

   task automatic same_cycle_requests();
      wb_data_t d_rdat;
      wb_data_t i_rdat;
      logic     d_ack;
      logic     d_err;
      logic     i_ack;
      logic     i_err;
      int       d_cycles;
      int       i_cycles;
      fork
         bus_access(1'b1, 32'h0000_0040, 1'b1, 4'hF, 32'h0A0B_0C0D, d_rdat, d_ack, d_err,
                    d_cycles);
         bus_access(1'b0, 32'hF000_0004, 1'b0, 4'hF, '0, i_rdat, i_ack, i_err, i_cycles);
      join
      expect_response("dbus", d_ack, d_err, 1'b1, d_cycles, 2);
      // dbus ack at 2, cyc drop and idle at 3, ibus grant at 4, ROM ack at 5
      expect_response("ibus", i_ack, i_err, 1'b1, i_cycles, 5);
      check_value("ibus_dat_o", i_rdat, `BOOTROM_SIGNATURE + 32'd1);
   endtask

   task automatic irq_toggles();
      int k;
      for (k = 0; k < 6; k++) begin
         @(negedge clk);
         eth_irq = ~eth_irq;
         @(posedge clk);
         #1;
         check_value("pic_ints_o", pic_ints, eth_irq ? 32'h1 << `ETH_IRQ_BIT : 32'h0);
      end
   endtask

   initial begin
      int k;
      rst_n   = 1'b0;
      eth_irq = 1'b0;
      drive_master(1'b0, 1'b0, '0, 1'b0, '0, '0);
      drive_master(1'b1, 1'b0, '0, 1'b0, '0, '0);
      for (k = 0; k < 8; k++) begin   // Reset for 8 cycles
         @(negedge clk);
         idle_outputs_low();
      end
      rst_n = 1'b1;
      @(posedge clk);
      #1;
      idle_outputs_low();
      irq_toggles();
      lmem_random_access();
      boot_rom_reads();
      unmapped_errors();
      external_ports();
      same_cycle_requests();
      irq_toggles();
      @(negedge clk);
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

// ==== sources.f ====
+incdir+include
hdl/wb_pkg.sv
hdl/tile_pkg.sv
hdl/wb_sram_sp.sv
hdl/bootrom.sv
hdl/wb_bus_arbiter.sv
hdl/wb_bus_decoder.sv
hdl/compute_tile_dm.sv
tb/tb_clock_gen.sv
tb/tb_compute_tile.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_compute_tile
RTL_TOP    := compute_tile_dm
FILELIST   := sources.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps

SOURCES := $(wildcard hdl/*.sv tb/*.sv include/*.svh)

.PHONY: all run lint clean

all: run

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
